// File: verilog/adc_test_pkg.sv
package adc_test_pkg;

    typedef logic [7:0]  lane_byte_t;
    typedef logic [7:0]  lane_mask_t;
    typedef logic [31:0] stat_word_t;
    typedef logic [31:0] cmd_word_t;
    typedef logic [3:0]  samp_div_t;
    typedef logic [11:0] work_count_t;

    typedef enum logic [3:0] {
        IDLE,
        WAIT,
        INIT_IDLE, INIT_WORK, INIT_DONE,
        TYPE_IDLE, TYPE_WORK, TYPE_DONE,
        CONF_IDLE, CONF_WORK, CONF_DONE,
        CONV_IDLE, CONV_WORK, CONV_DONE
    } seq_state_t;

    localparam work_count_t NUM_INIT = 12'd16;
    localparam work_count_t NUM_TYPE = 12'd16;
    localparam work_count_t NUM_CONF = 12'd32;

    localparam int NUM_LANES    = 8;
    localparam int BURST_LEN    = 16;
    localparam int BURST_CW     = $clog2(BURST_LEN) + 1;
    localparam int FIFO_DEPTH   = 8;
    localparam int FIFO_AW      = $clog2(FIFO_DEPTH);
    localparam int SAMP_DIV_LSB = 20; // Sample interval sits in cache_cmd[23:20]

    // Lane 7 occupies the top byte
    localparam logic [8*NUM_LANES-1:0] LANE_BIAS = 64'h01030507090B0D0F;

    localparam logic [7:0]  DEVICE_TYPE = 8'hFF;
    localparam logic [15:0] DEVICE_TEMP = 16'h73F4;
    localparam logic [3:0]  DEVICE_STAT = 4'hF;

endpackage

// File: verilog/adc_sequencer.sv
`timescale 1ns/100ps

module adc_sequencer (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     fs_init,
    input  logic                     fs_type,
    input  logic                     fs_conf,
    input  logic                     fs_conv,
    output logic                     fd_init,
    output logic                     fd_type,
    output logic                     fd_conf,
    output logic                     fd_conv,
    output logic                     burst_start,
    input  logic                     burst_done,
    output adc_test_pkg::stat_word_t cache_stat
);

    adc_test_pkg::seq_state_t  state;
    adc_test_pkg::seq_state_t  next_state;
    adc_test_pkg::work_count_t num;
    logic [15:0]               device_temp;
    logic [7:0]                device_type;

    assign cache_stat = {device_temp, device_type, adc_test_pkg::DEVICE_STAT, 4'h0};

    assign fd_init     = (state == adc_test_pkg::INIT_DONE);
    assign fd_type     = (state == adc_test_pkg::TYPE_DONE);
    assign fd_conf     = (state == adc_test_pkg::CONF_DONE);
    assign fd_conv     = (state == adc_test_pkg::CONV_DONE);
    assign burst_start = (state == adc_test_pkg::CONV_WORK);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= adc_test_pkg::IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            adc_test_pkg::IDLE: next_state = adc_test_pkg::WAIT;
            adc_test_pkg::WAIT: begin
                if (fs_init) begin // Fixed priority init, type, conf, conv
                    next_state = adc_test_pkg::INIT_IDLE;
                end else if (fs_type) begin
                    next_state = adc_test_pkg::TYPE_IDLE;
                end else if (fs_conf) begin
                    next_state = adc_test_pkg::CONF_IDLE;
                end else if (fs_conv) begin
                    next_state = adc_test_pkg::CONV_IDLE;
                end
            end

            adc_test_pkg::INIT_IDLE: next_state = adc_test_pkg::INIT_WORK;
            adc_test_pkg::INIT_WORK: begin
                if (num >= adc_test_pkg::NUM_INIT - 1'b1) begin
                    next_state = adc_test_pkg::INIT_DONE;
                end
            end
            adc_test_pkg::INIT_DONE: begin
                if (!fs_init) begin
                    next_state = adc_test_pkg::WAIT;
                end
            end

            adc_test_pkg::TYPE_IDLE: next_state = adc_test_pkg::TYPE_WORK;
            adc_test_pkg::TYPE_WORK: begin
                if (num >= adc_test_pkg::NUM_TYPE - 1'b1) begin
                    next_state = adc_test_pkg::TYPE_DONE;
                end
            end
            adc_test_pkg::TYPE_DONE: begin
                if (!fs_type) begin
                    next_state = adc_test_pkg::WAIT;
                end
            end

            adc_test_pkg::CONF_IDLE: next_state = adc_test_pkg::CONF_WORK;
            adc_test_pkg::CONF_WORK: begin
                if (num >= adc_test_pkg::NUM_CONF - 1'b1) begin
                    next_state = adc_test_pkg::CONF_DONE;
                end
            end
            adc_test_pkg::CONF_DONE: begin
                if (!fs_conf) begin
                    next_state = adc_test_pkg::WAIT;
                end
            end

            adc_test_pkg::CONV_IDLE: next_state = adc_test_pkg::CONV_WORK;
            adc_test_pkg::CONV_WORK: begin
                if (burst_done) begin // Length set by the generator, not by num
                    next_state = adc_test_pkg::CONV_DONE;
                end
            end
            adc_test_pkg::CONV_DONE: begin
                if (!fs_conv) begin
                    next_state = adc_test_pkg::WAIT;
                end
            end

            default: next_state = adc_test_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            num <= '0;
        end else if (state == adc_test_pkg::INIT_WORK || state == adc_test_pkg::TYPE_WORK ||
                     state == adc_test_pkg::CONF_WORK) begin
            num <= num + 1'b1;
        end else begin
            num <= '0;
        end
    end

    // Status fields latch as the FSM enters the matching IDLE state
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            device_type <= '0;
            device_temp <= '0;
        end else if (state == adc_test_pkg::IDLE) begin
            device_type <= '0;
            device_temp <= '0;
        end else begin
            if (next_state == adc_test_pkg::TYPE_IDLE) begin
                device_type <= adc_test_pkg::DEVICE_TYPE;
            end
            if (next_state == adc_test_pkg::CONF_IDLE) begin
                device_temp <= adc_test_pkg::DEVICE_TEMP;
            end
        end
    end

    a_one_done: assert property (@(posedge clk) disable iff (rst)
        $onehot0({fd_init, fd_type, fd_conf, fd_conv}));

endmodule

// File: verilog/sample_pattern_gen.sv
`timescale 1ns/100ps

module sample_pattern_gen (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 burst_start,
    input  adc_test_pkg::samp_div_t              samp_div,
    input  adc_test_pkg::lane_mask_t             lane_full,
    output adc_test_pkg::lane_mask_t             lane_wr,
    output logic [8*adc_test_pkg::NUM_LANES-1:0] lane_data,
    output logic                                 burst_done
);

    adc_test_pkg::samp_div_t           div_cnt;
    logic [adc_test_pkg::BURST_CW-1:0] wr_cnt;
    logic                              tick;
    logic                              wr;

    assign burst_done = (wr_cnt == adc_test_pkg::BURST_LEN);
    assign tick       = (div_cnt >= samp_div); // Tolerates samp_div dropping mid-burst
    assign wr         = burst_start && !burst_done && tick && (lane_full == '0);
    assign lane_wr    = {adc_test_pkg::NUM_LANES{wr}};

    always_comb begin
        for (int i = 0; i < adc_test_pkg::NUM_LANES; i++) begin
            lane_data[8*i +: 8] = adc_test_pkg::LANE_BIAS[8*i +: 8] +
                                  adc_test_pkg::lane_byte_t'(wr_cnt);
        end
    end

    // A due sample waits at the tick while a lane is full
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            div_cnt <= '0;
            wr_cnt  <= '0;
        end else if (!burst_start) begin
            div_cnt <= '0;
            wr_cnt  <= '0;
        end else if (wr) begin
            div_cnt <= '0;
            wr_cnt  <= wr_cnt + 1'b1;
        end else if (!tick) begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    a_no_write_full: assert property (@(posedge clk) disable iff (rst)
        (lane_wr != '0) |-> (lane_full == '0));

endmodule

// File: verilog/lane_fifo.sv
`timescale 1ns/100ps

module lane_fifo (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     wr_en,
    input  adc_test_pkg::lane_byte_t din,
    output logic                     full,
    input  logic                     rd_en,
    output adc_test_pkg::lane_byte_t dout,
    output logic                     empty
);

    adc_test_pkg::lane_byte_t         mem [adc_test_pkg::FIFO_DEPTH];
    logic [adc_test_pkg::FIFO_AW-1:0] wr_ptr;
    logic [adc_test_pkg::FIFO_AW-1:0] rd_ptr;
    logic [adc_test_pkg::FIFO_AW:0]   count;
    logic                             do_wr;
    logic                             do_rd;

    assign full  = (count == adc_test_pkg::FIFO_DEPTH);
    assign empty = (count == '0);
    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && !empty; // Reads on an empty FIFO are dropped

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= din;
        end
        if (do_rd) begin
            dout <= mem[rd_ptr]; // Held until the next accepted read
        end
    end

    a_no_write_full: assert property (@(posedge clk) disable iff (rst)
        wr_en |-> !full);

    a_count_bound: assert property (@(posedge clk) disable iff (rst)
        count <= adc_test_pkg::FIFO_DEPTH);

endmodule

// File: verilog/adc_test_top.sv
`timescale 1ns/100ps

module adc_test_top (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 fs_init,
    input  logic                                 fs_type,
    input  logic                                 fs_conf,
    input  logic                                 fs_conv,
    output logic                                 fd_init,
    output logic                                 fd_type,
    output logic                                 fd_conf,
    output logic                                 fd_conv,
    input  adc_test_pkg::cmd_word_t              cache_cmd,
    output adc_test_pkg::stat_word_t             cache_stat,
    input  adc_test_pkg::lane_mask_t             fifo_rxen,
    output logic [8*adc_test_pkg::NUM_LANES-1:0] fifo_rxd,
    output adc_test_pkg::lane_mask_t             fifo_empty
);

    logic                                 burst_start;
    logic                                 burst_done;
    adc_test_pkg::samp_div_t              samp_div;
    adc_test_pkg::lane_mask_t             lane_full;
    adc_test_pkg::lane_mask_t             lane_wr;
    logic [8*adc_test_pkg::NUM_LANES-1:0] lane_data;

    assign samp_div = cache_cmd[adc_test_pkg::SAMP_DIV_LSB +: $bits(adc_test_pkg::samp_div_t)];

    adc_sequencer i_sequencer (
        .clk         (clk),
        .rst         (rst),
        .fs_init     (fs_init),
        .fs_type     (fs_type),
        .fs_conf     (fs_conf),
        .fs_conv     (fs_conv),
        .fd_init     (fd_init),
        .fd_type     (fd_type),
        .fd_conf     (fd_conf),
        .fd_conv     (fd_conv),
        .burst_start (burst_start),
        .burst_done  (burst_done),
        .cache_stat  (cache_stat)
    );

    sample_pattern_gen i_pattern_gen (
        .clk         (clk),
        .rst         (rst),
        .burst_start (burst_start),
        .samp_div    (samp_div),
        .lane_full   (lane_full),
        .lane_wr     (lane_wr),
        .lane_data   (lane_data),
        .burst_done  (burst_done)
    );

    for (genvar i = 0; i < adc_test_pkg::NUM_LANES; i++) begin : g_lane
        lane_fifo i_fifo (
            .clk   (clk),
            .rst   (rst),
            .wr_en (lane_wr[i]),
            .din   (lane_data[8*i +: 8]),
            .full  (lane_full[i]),
            .rd_en (fifo_rxen[i]),
            .dout  (fifo_rxd[8*i +: 8]),
            .empty (fifo_empty[i])
        );
    end

endmodule

// File: verification/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk; // 20 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

// File: verification/adc_test_tb.sv
`timescale 1ns/100ps

module adc_test_tb;

    localparam int NUM_STEPS  = 9;
    localparam int WAIT_LIMIT = 2000;

    logic                        clk;
    logic                        rst;
    logic                        fs_init;
    logic                        fs_type;
    logic                        fs_conf;
    logic                        fs_conv;
    logic                        fd_init;
    logic                        fd_type;
    logic                        fd_conf;
    logic                        fd_conv;
    logic [3:0]                  fd_vec;
    adc_test_pkg::cmd_word_t     cache_cmd;
    adc_test_pkg::stat_word_t    cache_stat;
    adc_test_pkg::lane_mask_t    fifo_rxen;
    logic [63:0]                 fifo_rxd;
    adc_test_pkg::lane_mask_t    fifo_empty;
    logic [31:0]                 stim [4*NUM_STEPS];
    int                          errors = 0;
    integer                      seed = 51;

    assign fd_vec = {fd_conv, fd_conf, fd_type, fd_init};

    tb_clock_gen i_clock_gen (.clk(clk), .rst(rst));

    adc_test_top i_dut (.*);

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("Fail %0t %s expected %0h got %0h", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic wait_for_done(input logic [3:0] done_mask, output int cycles);
        cycles = 0;
        while ((fd_vec & done_mask) == 4'b0 && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        assert (cycles < WAIT_LIMIT) else begin
            $display("Error %0t the done output for mask %b never rose", $time, done_mask);
            errors++;
        end
    endtask

    // Runs init, type or conf; the lowest request bit wins as in WAIT
    task automatic run_timed(input logic [3:0] req);
        logic [3:0] won;
        int         latency;
        int         cycles;
        won     = req & (~req + 4'd1);
        latency = won[0] ? 17 : (won[1] ? 17 : 33);
        {fs_conv, fs_conf, fs_type, fs_init} = req;
        wait_for_done(4'hF, cycles);
        compare_value("done latency", latency, cycles - 1); // Counted from the start edge
        compare_value("fd_vec", won, fd_vec);
        repeat (3) begin
            @(negedge clk);
            compare_value("fd_vec held", won, fd_vec);
        end
        {fs_conv, fs_conf, fs_type, fs_init} = 4'b0;
        @(negedge clk);
        compare_value("fd_vec dropped", 4'b0, fd_vec);
    endtask

    task automatic run_convert(input adc_test_pkg::cmd_word_t cmd, input int hold);
        int cycles;
        cache_cmd = cmd;
        fs_conv   = 1'b1;
        repeat (hold) begin
            @(negedge clk);
            compare_value("fd_conv", 1'b0, fd_conv);
        end
        if (hold > 0) begin
            compare_value("lane_full", 8'hFF, i_dut.lane_full);
        end
        for (int n = 0; n < adc_test_pkg::BURST_LEN; n++) begin
            cycles = 0;
            while (fifo_empty != 8'h00 && cycles < WAIT_LIMIT) begin
                @(negedge clk);
                cycles++;
            end
            assert (cycles < WAIT_LIMIT) else begin
                $display("Error %0t byte %0d never arrived in the lanes", $time, n);
                errors++;
            end
            fifo_rxen = 8'hFF;
            @(negedge clk);
            fifo_rxen = 8'h00;
            for (int i = 0; i < adc_test_pkg::NUM_LANES; i++) begin
                // Lane 0 starts at 0x0F and each higher lane two lower
                compare_value($sformatf("fifo_rxd[%0d]", i), 8'(8'h0F - 2 * i + n),
                              fifo_rxd[8*i +: 8]);
            end
            repeat ({$random(seed)} % 4) @(negedge clk);
        end
        wait_for_done(4'b1000, cycles);
        compare_value("fd_vec", 4'b1000, fd_vec);
        fs_conv = 1'b0;
        @(negedge clk);
        compare_value("fd_conv dropped", 1'b0, fd_conv);
        compare_value("fifo_empty", 8'hFF, fifo_empty);
    endtask

    function automatic int run_length();
        int total;
        int div;
        total = 100;
        for (int s = 0; s < NUM_STEPS; s++) begin
            div   = (stim[4*s+1] >> 20) & 32'hF;
            total += 60 + stim[4*s+2] + adc_test_pkg::BURST_LEN * (div + 7);
        end
        return total;
    endfunction

    initial begin : watchdog
        int limit;
        #1;
        limit = run_length();
        #(limit * 20);
        $display("Watchdog expired after %0d cycles and the run did not complete", limit);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin : main
        fs_init   = 1'b0;
        fs_type   = 1'b0;
        fs_conf   = 1'b0;
        fs_conv   = 1'b0;
        cache_cmd = '0;
        fifo_rxen = '0;
        $readmemh("verification/adc_test_stimulus.txt", stim);
        @(negedge rst);
        @(negedge clk);
        compare_value("fd_vec", 4'b0, fd_vec);
        compare_value("cache_stat", 32'h000000F0, cache_stat);
        compare_value("fifo_empty", 8'hFF, fifo_empty);
        for (int s = 0; s < NUM_STEPS; s++) begin
            if (stim[4*s][3]) begin
                run_convert(stim[4*s+1], stim[4*s+2]);
            end else begin
                run_timed(stim[4*s][3:0]);
            end
            compare_value("cache_stat", stim[4*s+3], cache_stat);
        end
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: verification/adc_test_stimulus.txt
// Columns: request mask (1 init, 2 type, 4 conf, 8 conv), command word,
// read hold-off cycles before draining, expected cache_stat after the step
1 00000000 00 000000F0
2 00000000 00 0000FFF0
4 00000000 00 73F4FFF0
5 00000000 00 73F4FFF0
8 00000000 00 73F4FFF0
8 00300000 00 73F4FFF0
8 00700000 00 73F4FFF0
8 00100000 28 73F4FFF0
8 00F00000 00 73F4FFF0

// File: list.f
verilog/adc_test_pkg.sv
verilog/adc_sequencer.sv
verilog/sample_pattern_gen.sv
verilog/lane_fifo.sv
verilog/adc_test_top.sv
verification/tb_clock_gen.sv
verification/adc_test_tb.sv

// File: Bender.yml
package:
  name: adc_test

sources:
  - verilog/adc_test_pkg.sv
  - verilog/adc_sequencer.sv
  - verilog/sample_pattern_gen.sv
  - verilog/lane_fifo.sv
  - verilog/adc_test_top.sv
  - target: test
    files:
      - verification/tb_clock_gen.sv
      - verification/adc_test_tb.sv
